// File: design/cpu_pkg.sv
`default_nettype none

package cpu_pkg;

    localparam int xlen = 32;

    typedef logic [xlen-1:0] word_t;
    typedef logic [4:0]      reg_index_t;
    typedef logic [31:0]     instr_t;

    localparam logic [1:0] size_word = 2'd2;  // Memory size code for 32 bits
    localparam word_t instruction_bytes = word_t'(4);

    // Upper five opcode bits, low two bits are always 2'b11
    typedef enum logic [4:0] {
        op_imm = 5'b00100,
        auipc  = 5'b00101,
        store  = 5'b01000,
        op     = 5'b01100,
        lui    = 5'b01101,
        branch = 5'b11000,
        jal    = 5'b11011
    } opcode_e;

    typedef struct packed {
        word_t      address;
        word_t      data;
        logic [1:0] size;
        logic       write;  // 1 for store
    } mem_request_t;

    typedef enum logic [1:0] {
        owner_idle,
        owner_fetch,
        owner_store
    } owner_e;

    typedef struct packed {
        logic  valid;
        word_t target;
    } redirect_t;

endpackage

`default_nettype wire

// File: design/register_file.sv
`default_nettype none

module register_file import cpu_pkg::*; (
    input  logic       clock,
    input  logic       reset,
    input  reg_index_t read_index_1,
    input  reg_index_t read_index_2,
    output word_t      read_data_1,
    output word_t      read_data_2,
    input  logic       write_enable,
    input  reg_index_t write_index,
    input  word_t      write_data
);

    word_t registers [1:31];  // x0 has no storage

    assign read_data_1 = (read_index_1 == '0) ? '0 : registers[read_index_1];
    assign read_data_2 = (read_index_2 == '0) ? '0 : registers[read_index_2];

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            for (int i = 1; i < 32; i++) begin
                registers[i] <= '0;
            end
        end else if (write_enable && write_index != '0) begin
            registers[write_index] <= write_data;
        end
    end

endmodule

`default_nettype wire

// File: design/execute_unit.sv
`default_nettype none

module execute_unit import cpu_pkg::*; (
    input  logic         clock,
    input  logic         reset,
    input  instr_t       instruction,
    input  word_t        instruction_pc,
    input  logic         instruction_valid,
    output logic         instruction_taken,
    output redirect_t    redirect,
    input  logic         store_busy,
    output logic         store_push,
    output mem_request_t store_push_request
);

    opcode_e    opcode;
    logic [2:0] function_3;
    reg_index_t source_1_index;
    reg_index_t source_2_index;
    reg_index_t destination_index;
    word_t      source_1;
    word_t      source_2;
    word_t      immediate_i;
    word_t      immediate_s;
    word_t      immediate_b;
    word_t      immediate_u;
    word_t      immediate_j;
    word_t      operand_b;
    word_t      alu_result;
    word_t      write_data;
    logic       base_encoding;
    logic       branch_condition;
    logic       writes_destination;
    logic       jump;
    logic       is_store_word;

    assign base_encoding     = instruction[1:0] == 2'b11;
    assign opcode            = opcode_e'(instruction[6:2]);
    assign function_3        = instruction[14:12];
    assign source_1_index    = instruction[19:15];
    assign source_2_index    = instruction[24:20];
    assign destination_index = instruction[11:7];

    assign immediate_i = {{21{instruction[31]}}, instruction[30:20]};
    assign immediate_s = {{21{instruction[31]}}, instruction[30:25], instruction[11:7]};
    assign immediate_b = {{20{instruction[31]}}, instruction[7], instruction[30:25],
                          instruction[11:8], 1'b0};
    assign immediate_u = {instruction[31:12], 12'b0};
    assign immediate_j = {{12{instruction[31]}}, instruction[19:12], instruction[20],
                          instruction[30:21], 1'b0};

    register_file registers (
        .clock        (clock),
        .reset        (reset),
        .read_index_1 (source_1_index),
        .read_index_2 (source_2_index),
        .read_data_1  (source_1),
        .read_data_2  (source_2),
        .write_enable (writes_destination && instruction_taken),
        .write_index  (destination_index),
        .write_data   (write_data)
    );

    assign operand_b = (opcode == op) ? source_2 : immediate_i;

    always_comb begin
        case (function_3)
            3'b000:  alu_result = (opcode == op && instruction[30]) ? source_1 - operand_b
                                                                     : source_1 + operand_b;
            3'b001:  alu_result = source_1 << operand_b[4:0];
            3'b010:  alu_result = word_t'($signed(source_1) < $signed(operand_b));
            3'b011:  alu_result = word_t'(source_1 < operand_b);
            3'b100:  alu_result = source_1 ^ operand_b;
            3'b101:  alu_result = instruction[30] ? word_t'($signed(source_1) >>> operand_b[4:0])
                                                  : source_1 >> operand_b[4:0];
            3'b110:  alu_result = source_1 | operand_b;
            default: alu_result = source_1 & operand_b;
        endcase
    end

    always_comb begin
        case (function_3)
            3'b000:  branch_condition = source_1 == source_2;
            3'b001:  branch_condition = source_1 != source_2;
            3'b100:  branch_condition = $signed(source_1) < $signed(source_2);
            3'b101:  branch_condition = $signed(source_1) >= $signed(source_2);
            3'b110:  branch_condition = source_1 < source_2;
            3'b111:  branch_condition = source_1 >= source_2;
            default: branch_condition = 1'b0;
        endcase
    end

    always_comb begin
        writes_destination = 1'b0;
        write_data         = alu_result;
        jump               = 1'b0;
        is_store_word      = 1'b0;
        if (base_encoding) begin
            case (opcode)
                op_imm, op: writes_destination = 1'b1;
                lui: begin
                    writes_destination = 1'b1;
                    write_data         = immediate_u;
                end
                auipc: begin
                    writes_destination = 1'b1;
                    write_data         = instruction_pc + immediate_u;
                end
                jal: begin
                    writes_destination = 1'b1;
                    write_data         = instruction_pc + instruction_bytes;  // Link
                    jump               = 1'b1;
                end
                branch:  jump = branch_condition;
                store:   is_store_word = function_3 == 3'b010;  // SB and SH retire as no-ops
                default: ;
            endcase
        end
    end

    // Wait out the redirect cycle and any store still in the buffer
    assign instruction_taken = instruction_valid && !redirect.valid
                               && !(is_store_word && store_busy);

    assign store_push         = instruction_taken && is_store_word;
    assign store_push_request = '{address: source_1 + immediate_s, data: source_2,
                                  size: size_word, write: 1'b1};

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            redirect <= '0;
        end else begin
            redirect.valid  <= instruction_taken && jump;
            redirect.target <= instruction_pc + ((opcode == jal) ? immediate_j : immediate_b);
        end
    end

    a_held_until_taken: assert property (
        @(posedge clock) disable iff (reset)
            instruction_valid && !instruction_taken && !redirect.valid
                |=> instruction_valid && $stable(instruction) && $stable(instruction_pc)
    );

endmodule

`default_nettype wire

// File: design/fetch_unit.sv
`default_nettype none

module fetch_unit import cpu_pkg::*; #(
    parameter word_t reset_pc = '0
) (
    input  logic         clock,
    input  logic         reset,
    output logic         fetch_want,
    output mem_request_t fetch_request,
    input  logic         fetch_done,
    input  word_t        read_data,
    input  logic         store_busy,
    input  redirect_t    redirect,
    output instr_t       instruction,
    output word_t        instruction_pc,
    output logic         instruction_valid,
    input  logic         instruction_taken
);

    word_t program_counter;
    logic  cancel_pending;  // Word in flight belongs to the old path
    logic  start_fetch;

    assign start_fetch = !fetch_want && (!instruction_valid || instruction_taken) && !store_busy;

    assign fetch_request = '{address: program_counter, data: '0, size: size_word, write: 1'b0};

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            program_counter   <= reset_pc;
            fetch_want        <= 1'b0;
            cancel_pending    <= 1'b0;
            instruction_valid <= 1'b0;
        end else begin
            if (instruction_taken) begin
                instruction_valid <= 1'b0;
            end
            if (fetch_done) begin
                fetch_want     <= 1'b0;
                cancel_pending <= 1'b0;
                if (!cancel_pending && !redirect.valid) begin
                    instruction_valid <= 1'b1;
                    program_counter   <= program_counter + instruction_bytes;
                end
            end else if (start_fetch) begin
                fetch_want <= 1'b1;
            end
            if (redirect.valid) begin
                program_counter   <= redirect.target;
                instruction_valid <= 1'b0;
                if (fetch_want && !fetch_done) begin
                    cancel_pending <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clock) begin
        if (fetch_done) begin
            instruction    <= read_data;
            instruction_pc <= program_counter;
        end
    end

    a_no_take_on_redirect: assert property (
        @(posedge clock) disable iff (reset) redirect.valid |-> !instruction_taken
    );

endmodule

`default_nettype wire

// File: design/store_unit.sv
`default_nettype none

module store_unit import cpu_pkg::*; (
    input  logic         clock,
    input  logic         reset,
    input  logic         store_push,
    input  mem_request_t store_push_request,
    output logic         store_busy,
    output logic         store_want,
    output mem_request_t store_request,
    input  logic         store_done
);

    logic         pending;
    mem_request_t held_request;

    assign store_busy    = pending;
    assign store_want    = pending;
    assign store_request = held_request;

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            pending <= 1'b0;
        end else if (store_push) begin
            pending <= 1'b1;
        end else if (store_done) begin
            pending <= 1'b0;
        end
    end

    // Only full words go out
    always_ff @(posedge clock) begin
        if (store_push) begin
            held_request <= '{address: store_push_request.address,
                              data: store_push_request.data,
                              size: size_word, write: 1'b1};
        end
    end

    a_done_only_when_wanted: assert property (
        @(posedge clock) disable iff (reset) store_done |-> store_want
    );

endmodule

`default_nettype wire

// File: design/memory_arbiter.sv
`default_nettype none

module memory_arbiter import cpu_pkg::*; (
    input  logic         clock,
    input  logic         reset,
    input  logic         fetch_want,
    input  logic         store_want,
    input  mem_request_t fetch_request,
    input  mem_request_t store_request,
    output logic         fetch_done,
    output logic         store_done,
    output word_t        read_data,
    output word_t        memory_address,
    output word_t        memory_data_out,
    output logic [1:0]   memory_data_size,
    output logic         memory_enable,
    output logic         memory_operation,
    input  word_t        memory_data_in,
    input  logic         memory_ready
);

    owner_e       owner;
    logic         grant;
    logic         transfer_end;
    mem_request_t granted_request;

    // Memory must have dropped ready from the last transfer
    assign grant           = owner == owner_idle && !memory_ready && (store_want || fetch_want);
    assign granted_request = store_want ? store_request : fetch_request;  // Store first
    assign transfer_end    = memory_enable && memory_ready;

    assign fetch_done = transfer_end && owner == owner_fetch;
    assign store_done = transfer_end && owner == owner_store;
    assign read_data  = memory_data_in;

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            owner         <= owner_idle;
            memory_enable <= 1'b0;
        end else if (grant) begin
            owner         <= store_want ? owner_store : owner_fetch;
            memory_enable <= 1'b1;
        end else if (transfer_end) begin
            owner         <= owner_idle;
            memory_enable <= 1'b0;
        end
    end

    always_ff @(posedge clock) begin
        if (grant) begin
            memory_address   <= granted_request.address;
            memory_data_out  <= granted_request.data;
            memory_data_size <= granted_request.size;
            memory_operation <= granted_request.write;
        end
    end

    a_enable_has_owner: assert property (
        @(posedge clock) disable iff (reset)
            memory_enable |-> (owner == owner_fetch && fetch_want)
                              || (owner == owner_store && store_want)
    );

endmodule

`default_nettype wire

// File: design/cpu_top.sv
`default_nettype none

module cpu_top import cpu_pkg::*; #(
    parameter word_t reset_pc = '0
) (
    input  logic       clock,
    input  logic       reset,
    output word_t      memory_address,
    output word_t      memory_data_out,
    output logic [1:0] memory_data_size,
    output logic       memory_enable,
    output logic       memory_operation,
    input  word_t      memory_data_in,
    input  logic       memory_ready
);

    logic         fetch_want;
    logic         fetch_done;
    mem_request_t fetch_request;
    logic         store_want;
    logic         store_done;
    mem_request_t store_request;
    word_t        read_data;
    instr_t       instruction;
    word_t        instruction_pc;
    logic         instruction_valid;
    logic         instruction_taken;
    redirect_t    redirect;
    logic         store_busy;
    logic         store_push;
    mem_request_t store_push_request;

    fetch_unit #(.reset_pc(reset_pc)) fetch (
        .clock             (clock),
        .reset             (reset),
        .fetch_want        (fetch_want),
        .fetch_request     (fetch_request),
        .fetch_done        (fetch_done),
        .read_data         (read_data),
        .store_busy        (store_busy),
        .redirect          (redirect),
        .instruction       (instruction),
        .instruction_pc    (instruction_pc),
        .instruction_valid (instruction_valid),
        .instruction_taken (instruction_taken)
    );

    execute_unit execute (
        .clock              (clock),
        .reset              (reset),
        .instruction        (instruction),
        .instruction_pc     (instruction_pc),
        .instruction_valid  (instruction_valid),
        .instruction_taken  (instruction_taken),
        .redirect           (redirect),
        .store_busy         (store_busy),
        .store_push         (store_push),
        .store_push_request (store_push_request)
    );

    store_unit store_buffer (
        .clock              (clock),
        .reset              (reset),
        .store_push         (store_push),
        .store_push_request (store_push_request),
        .store_busy         (store_busy),
        .store_want         (store_want),
        .store_request      (store_request),
        .store_done         (store_done)
    );

    memory_arbiter arbiter (
        .clock            (clock),
        .reset            (reset),
        .fetch_want       (fetch_want),
        .store_want       (store_want),
        .fetch_request    (fetch_request),
        .store_request    (store_request),
        .fetch_done       (fetch_done),
        .store_done       (store_done),
        .read_data        (read_data),
        .memory_address   (memory_address),
        .memory_data_out  (memory_data_out),
        .memory_data_size (memory_data_size),
        .memory_enable    (memory_enable),
        .memory_operation (memory_operation),
        .memory_data_in   (memory_data_in),
        .memory_ready     (memory_ready)
    );

endmodule

`default_nettype wire

// File: dv/tb_cpu.sv
`default_nettype none

module tb_cpu import cpu_pkg::*; ();

    localparam int rows       = 8;
    localparam int max_words  = 12;
    localparam int max_stores = 5;
    // Each word needs at most a fetch and a store of six cycles each
    localparam int watchdog_time = rows * (max_words * 12 + 3) * 100;

    typedef struct packed {
        word_t address;
        word_t data;
    } store_entry_t;

    logic       clock;
    logic       reset;
    word_t      memory_address;
    word_t      memory_data_out;
    logic [1:0] memory_data_size;
    logic       memory_enable;
    logic       memory_operation;
    word_t      memory_data_in;
    logic       memory_ready;

    instr_t       programs [rows][max_words];
    store_entry_t expected [rows][max_stores];
    int           program_words [rows];
    int           store_count [rows];
    string        row_names [rows];
    word_t        memory [256];
    logic [31:0]  random_state = 32'h807;
    int           current_row;
    int           stores_seen;
    int           wait_cycles;
    int           errors;
    int           failed_rows;
    logic         first_transfer;
    logic         past_end;  // A fetch went beyond the program
    logic         row_active;
    logic         row_done;

    cpu_top #(.reset_pc(32'h0)) DUT (
        .clock            (clock),
        .reset            (reset),
        .memory_address   (memory_address),
        .memory_data_out  (memory_data_out),
        .memory_data_size (memory_data_size),
        .memory_enable    (memory_enable),
        .memory_operation (memory_operation),
        .memory_data_in   (memory_data_in),
        .memory_ready     (memory_ready)
    );

    always #50 clock = ~clock;

    function automatic logic [31:0] next_random();
        random_state = random_state ^ (random_state << 13);
        random_state = random_state ^ (random_state >> 17);
        random_state = random_state ^ (random_state << 5);
        return random_state;
    endfunction

    function automatic instr_t alu_imm(input int f3, input int rd, input int rs1, input int imm);
        return {imm[11:0], rs1[4:0], f3[2:0], rd[4:0], 7'h13};
    endfunction

    function automatic instr_t alu_reg(input int f7, input int f3, input int rd, input int rs1,
                                       input int rs2);
        return {f7[6:0], rs2[4:0], rs1[4:0], f3[2:0], rd[4:0], 7'h33};
    endfunction

    function automatic instr_t store_word(input int rs2, input int offset);
        return {offset[11:5], rs2[4:0], 5'd0, 3'b010, offset[4:0], 7'h23};
    endfunction

    function automatic instr_t upper_imm(input int opcode, input int rd, input int imm);
        return {imm[19:0], rd[4:0], opcode[6:0]};
    endfunction

    function automatic instr_t branch_to(input int f3, input int rs1, input int rs2,
                                         input int offset);
        return {offset[12], offset[10:5], rs2[4:0], rs1[4:0], f3[2:0], offset[4:1], offset[11],
                7'h63};
    endfunction

    function automatic instr_t jump_to(input int rd, input int offset);
        return {offset[20], offset[10:1], offset[11], offset[19:12], rd[4:0], 7'h6f};
    endfunction

    task automatic note_failure(input string message);
        $display("Failure at %0t: %s", $time, message);
        errors++;
    endtask

    task automatic check_word(input string name, input word_t actual, input word_t wanted);
        if (actual !== wanted) begin
            $display("Error at %0t: %s is %h, expected %h", $time, name, actual, wanted);
            errors++;
        end
    endtask

    task automatic check_address(input string name, input word_t actual, input word_t wanted);
        if (actual !== wanted) begin
            $display("Error at %0t: %s is %h, expected %h", $time, name, actual, wanted);
            errors++;
        end
    endtask

    task automatic check_size(input string name, input logic [1:0] actual,
                              input logic [1:0] wanted);
        if (actual !== wanted) begin
            $display("Error at %0t: %s is %h, expected %h", $time, name, actual, wanted);
            errors++;
        end
    endtask

    task automatic fill_table();
        row_names = '{"immediate alu", "immediate shifts", "register alu a", "register alu b",
                      "x0 lui auipc", "beq bne blt", "bge bltu bgeu", "jal"};
        program_words = '{11, 10, 12, 12, 10, 12, 12, 11};
        store_count   = '{5, 4, 5, 5, 4, 1, 1, 3};
        programs[0] = '{alu_imm(0, 1, 0, -5), alu_imm(3'b010, 2, 1, 1), alu_imm(3'b011, 3, 1, 1),
            alu_imm(3'b100, 4, 1, 'h0f0), alu_imm(3'b110, 5, 1, 'h004), alu_imm(3'b111, 6, 1, 'h0ff),
            store_word(2, 'h100), store_word(3, 'h104), store_word(4, 'h108),
            store_word(5, 'h10c), store_word(6, 'h110), 32'h0};
        expected[0] = '{'{32'h100, 32'h1}, '{32'h104, 32'h0}, '{32'h108, 32'hffffff0b},
            '{32'h10c, 32'hffffffff}, '{32'h110, 32'hfb}};
        programs[1] = '{alu_imm(0, 1, 0, -16), alu_imm(3'b001, 2, 1, 4), alu_imm(3'b101, 3, 1, 4),
            alu_imm(3'b101, 4, 1, 'h404), alu_imm(0, 5, 0, 'h7f0), alu_imm(3'b101, 6, 5, 'h404),
            store_word(2, 'h100), store_word(3, 'h104), store_word(4, 'h108),
            store_word(6, 'h10c), 32'h0, 32'h0};
        expected[1] = '{'{32'h100, 32'hffffff00}, '{32'h104, 32'h0fffffff},
            '{32'h108, 32'hffffffff}, '{32'h10c, 32'h7f}, '0};
        programs[2] = '{alu_imm(0, 1, 0, -7), alu_imm(0, 2, 0, 3), alu_reg(0, 0, 3, 1, 2),
            alu_reg('h20, 0, 4, 2, 1), alu_reg(0, 3'b010, 5, 1, 2), alu_reg(0, 3'b011, 6, 1, 2),
            alu_reg(0, 3'b100, 7, 1, 2), store_word(3, 'h100), store_word(4, 'h104),
            store_word(5, 'h108), store_word(6, 'h10c), store_word(7, 'h110)};
        expected[2] = '{'{32'h100, 32'hfffffffc}, '{32'h104, 32'ha}, '{32'h108, 32'h1},
            '{32'h10c, 32'h0}, '{32'h110, 32'hfffffffa}};
        programs[3] = '{alu_imm(0, 1, 0, -7), alu_imm(0, 2, 0, 3), alu_reg(0, 3'b110, 3, 1, 2),
            alu_reg(0, 3'b111, 4, 1, 2), alu_reg(0, 3'b001, 5, 2, 2), alu_reg(0, 3'b101, 6, 1, 2),
            alu_reg('h20, 3'b101, 7, 1, 2), store_word(3, 'h100), store_word(4, 'h104),
            store_word(5, 'h108), store_word(6, 'h10c), store_word(7, 'h110)};
        expected[3] = '{'{32'h100, 32'hfffffffb}, '{32'h104, 32'h1}, '{32'h108, 32'h18},
            '{32'h10c, 32'h1fffffff}, '{32'h110, 32'hffffffff}};
        programs[4] = '{alu_imm(0, 1, 0, -1), alu_reg(0, 0, 0, 1, 1), alu_imm(0, 0, 0, 5),
            upper_imm('h37, 2, 'h80001), upper_imm('h17, 3, 'h00012), store_word(0, 'h100),
            store_word(2, 'h104), store_word(3, 'h108), upper_imm('h17, 4, 'hfffff),
            store_word(4, 'h10c), 32'h0, 32'h0};
        expected[4] = '{'{32'h100, 32'h0}, '{32'h104, 32'h80001000}, '{32'h108, 32'h00012010},
            '{32'h10c, 32'hfffff020}, '0};
        // Not taken then taken per condition, the skipped store goes to 0x1f0
        programs[5] = '{alu_imm(0, 1, 0, -2), alu_imm(0, 2, 0, 3), branch_to(3'b000, 1, 2, 8),
            branch_to(3'b000, 1, 1, 8), store_word(1, 'h1f0), branch_to(3'b001, 1, 1, 8),
            branch_to(3'b001, 1, 2, 8), store_word(1, 'h1f0), branch_to(3'b100, 2, 1, 8),
            branch_to(3'b100, 1, 2, 8), store_word(1, 'h1f0), store_word(2, 'h100)};
        expected[5] = '{'{32'h100, 32'h3}, '0, '0, '0, '0};
        programs[6] = '{alu_imm(0, 1, 0, -2), alu_imm(0, 2, 0, 3), branch_to(3'b101, 1, 2, 8),
            branch_to(3'b101, 2, 1, 8), store_word(1, 'h1f0), branch_to(3'b110, 1, 2, 8),
            branch_to(3'b110, 2, 1, 8), store_word(1, 'h1f0), branch_to(3'b111, 2, 1, 8),
            branch_to(3'b111, 1, 2, 8), store_word(1, 'h1f0), store_word(1, 'h100)};
        expected[6] = '{'{32'h100, 32'hfffffffe}, '0, '0, '0, '0};
        programs[7] = '{alu_imm(0, 1, 0, 9), jump_to(5, 12), store_word(1, 'h1f0),
            store_word(1, 'h1f0), store_word(5, 'h100), jump_to(0, 12), store_word(6, 'h108),
            jump_to(0, 12), jump_to(6, -8), store_word(1, 'h1f0), store_word(1, 'h104), 32'h0};
        expected[7] = '{'{32'h100, 32'h8}, '{32'h108, 32'h24}, '{32'h104, 32'h9}, '0, '0};
    endtask

    task automatic load_row(input int row);
        for (int i = 0; i < 256; i++) begin
            memory[i] = word_t'(i * 4);  // Own address, decodes as a no-op
        end
        for (int i = 0; i < program_words[row]; i++) begin
            memory[i] = programs[row][i];
        end
        current_row    = row;
        stores_seen    = 0;
        past_end       = 1'b0;
        first_transfer = 1'b1;
        wait_cycles    = 0;
    endtask

    task automatic begin_transfer();
        wait_cycles = 1 + int'(next_random() % 4);
        if (first_transfer) begin
            check_address("memory_address", memory_address, 32'h0);
            check_size("memory_data_size", memory_data_size, size_word);
            if (memory_operation) begin
                note_failure("first transfer after reset is a write");
            end
            first_transfer = 1'b0;
        end
        if (!memory_operation && memory_address >= word_t'(program_words[current_row] * 4)) begin
            past_end = 1'b1;
        end
    endtask

    task automatic complete_transfer();
        memory_ready = 1'b1;
        if (memory_operation) begin
            memory[memory_address[9:2]] = memory_data_out;
            if (stores_seen >= store_count[current_row]) begin
                note_failure($sformatf("unexpected store of %h to %h", memory_data_out,
                                       memory_address));
            end else begin
                check_address("memory_address", memory_address,
                              expected[current_row][stores_seen].address);
                check_word("memory_data_out", memory_data_out,
                           expected[current_row][stores_seen].data);
                check_size("memory_data_size", memory_data_size, size_word);
            end
            stores_seen++;
        end else begin
            memory_data_in = memory[memory_address[9:2]];
        end
    endtask

    always @(negedge clock) begin
        if (reset) begin
            memory_ready = 1'b0;
            wait_cycles  = 0;
            if (memory_enable) begin
                note_failure("memory_enable is high during reset");
            end
        end else if (memory_ready) begin
            memory_ready = 1'b0;
        end else if (memory_enable) begin
            if (wait_cycles == 0) begin
                begin_transfer();
            end
            wait_cycles--;
            if (wait_cycles == 0) begin
                complete_transfer();
            end
        end
        // Port idle and nothing more to wait for
        if (row_active && !reset && !memory_enable && !memory_ready
            && (stores_seen == store_count[current_row] || past_end)) begin
            row_done = 1'b1;
        end
    end

    initial begin
        int errors_before;
        clock          = 1'b0;
        reset          = 1'b1;
        memory_ready   = 1'b0;
        memory_data_in = '0;
        row_active     = 1'b0;
        row_done       = 1'b0;
        errors         = 0;
        failed_rows    = 0;
        fill_table();
        for (int r = 0; r < rows; r++) begin
            errors_before = errors;
            load_row(r);
            reset = 1'b1;
            repeat (3) @(negedge clock);
            reset      = 1'b0;
            row_active = 1'b1;
            wait (row_done);
            row_active = 1'b0;
            row_done   = 1'b0;
            if (stores_seen != store_count[r]) begin
                note_failure($sformatf("row ended after %0d of %0d stores", stores_seen,
                                       store_count[r]));
            end
            if (errors != errors_before) begin
                failed_rows++;
            end
            $display("row %0d %s: %0d stores, %0d errors", r, row_names[r], stores_seen,
                     errors - errors_before);
        end
        $display("rows run %0d, rows with errors %0d, errors %0d", rows, failed_rows, errors);
        if (errors == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

    initial begin
        #(watchdog_time);
        $display("Watchdog expired before all programs finished");
        $display("test failed");
        $finish;
    end

endmodule

`default_nettype wire

// File: vlog.f
design/cpu_pkg.sv
design/register_file.sv
design/execute_unit.sv
design/fetch_unit.sv
design/store_unit.sv
design/memory_arbiter.sv
design/cpu_top.sv
dv/tb_cpu.sv

// File: Bender.yml
package:
  name: rv32i_subset_core

sources:
  - design/cpu_pkg.sv
  - design/register_file.sv
  - design/execute_unit.sv
  - design/fetch_unit.sv
  - design/store_unit.sv
  - design/memory_arbiter.sv
  - design/cpu_top.sv
  - target: test
    files:
      - dv/tb_cpu.sv
